// File: logic/pdp8Pkg.sv
/*
 * Shared types for the PDP-8/L style core.
 * Word, opcode and state encodings used by the RTL and the testbench.
 * Referenced everywhere by scoped names.
 */
package pdp8Pkg;

    typedef logic [11:0] word_t;    // machine word, also MA/PC/switch register
    typedef logic [2:0]  opcode_t;  // IR field, top three bits of the instruction

    // major states, one memory cycle each except HALT
    typedef enum logic [2:0] {
        HALT,
        FETCH,
        DEFER,
        EXEC,
        DEPOSIT,
        EXAMINE
    } majorState_t;

    // time states of one memory cycle
    typedef enum logic [2:0] {
        IDLE,
        TS1,    // read core into MB
        TS2,    // modify MB
        TS3,    // write MB back
        TS4     // finish, update registers
    } timeState_t;

    localparam opcode_t OP_AND = 3'd0;
    localparam opcode_t OP_TAD = 3'd1;
    localparam opcode_t OP_ISZ = 3'd2;
    localparam opcode_t OP_DCA = 3'd3;
    localparam opcode_t OP_JMS = 3'd4;
    localparam opcode_t OP_JMP = 3'd5;
    localparam opcode_t OP_IOT = 3'd6;  // no IO bus here, runs as a no-op
    localparam opcode_t OP_OPR = 3'd7;

endpackage

// File: logic/consoleKeyIf.sv
/*
 * Front-panel key pulses from the debouncer to the major-state control.
 * Each line is a single-clock pulse after a debounced release.
 */
interface consoleKeyIf;

    logic loadAddr;     // LOAD ADDRESS
    logic deposit;
    logic examine;
    logic cont;         // CONTINUE
    logic start;

    modport source (output loadAddr, deposit, examine, cont, start);
    modport sink   (input  loadAddr, deposit, examine, cont, start);

endinterface

// File: logic/consoleKeys.sv
/*
 * Debounce for the momentary panel switches.
 * A key acts on release, and only if some key was held DEBOUNCE_CYCLES clocks.
 * Pulses go out on the consoleKeyIf source side.
 */
module consoleKeys #(
    parameter int DEBOUNCE_CYCLES = 1000
) (
    input  logic          CLOCK,
    input  logic          RESET,
    input  logic          i_swLoadAddr,
    input  logic          i_swDeposit,
    input  logic          i_swExamine,
    input  logic          i_swContinue,
    input  logic          i_swStart,
    consoleKeyIf.source   keys
);

    localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);

    logic [4:0]    sw;          // loadAddr, deposit, examine, cont, start
    logic [4:0]    prevSw;      // last sampled switch levels
    logic [4:0]    pulse;
    logic [CW-1:0] holdCount;
    logic          held;

    assign sw   = {i_swLoadAddr, i_swDeposit, i_swExamine, i_swContinue, i_swStart};
    assign held = (holdCount == CW'(DEBOUNCE_CYCLES));   // saturates here

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            holdCount <= '0;
            prevSw    <= '0;
            pulse     <= '0;
        end else begin
            if (sw == '0)
                holdCount <= '0;                    // all keys up, start over
            else if (!held)
                holdCount <= holdCount + 1'b1;
            prevSw <= sw;
            pulse  <= held ? (prevSw & ~sw) : '0;   // falling edge of a held key
        end
    end

    assign keys.loadAddr = pulse[4];
    assign keys.deposit  = pulse[3];
    assign keys.examine  = pulse[2];
    assign keys.cont     = pulse[1];
    assign keys.start    = pulse[0];

endmodule

// File: logic/memoryTiming.sv
/*
 * Time-state generator for the core memory cycle.
 * i_cycleStart kicks off TS1; each time state lasts PHASE_CYCLES clocks and
 * o_phaseEnd marks its last clock. A start at the end of TS4 chains cycles.
 */
module memoryTiming #(
    parameter int PHASE_CYCLES = 4
) (
    input  logic                CLOCK,
    input  logic                RESET,
    input  logic                i_cycleStart,
    output pdp8Pkg::timeState_t o_timeState,
    output logic                o_phaseEnd
);

    localparam int PW = $clog2(PHASE_CYCLES + 1);

    pdp8Pkg::timeState_t state;
    logic [PW-1:0]       phaseCount;
    logic                phaseDone;

    assign phaseDone = (state != pdp8Pkg::IDLE) && (phaseCount == PW'(PHASE_CYCLES - 1));

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            state      <= pdp8Pkg::IDLE;
            phaseCount <= '0;
        end else if (state == pdp8Pkg::IDLE) begin
            phaseCount <= '0;
            if (i_cycleStart)
                state <= pdp8Pkg::TS1;
        end else if (phaseDone) begin
            phaseCount <= '0;
            case (state)
                pdp8Pkg::TS1: state <= pdp8Pkg::TS2;
                pdp8Pkg::TS2: state <= pdp8Pkg::TS3;
                pdp8Pkg::TS3: state <= pdp8Pkg::TS4;
                default:      state <= i_cycleStart ? pdp8Pkg::TS1 : pdp8Pkg::IDLE;
            endcase
        end else begin
            phaseCount <= phaseCount + 1'b1;
        end
    end

    assign o_timeState = state;
    assign o_phaseEnd  = phaseDone;

endmodule

// File: logic/coreMemory.sv
/*
 * Internal core stack, 2^ADDR_BITS words.
 * Registered read, one clock behind the address, and synchronous write.
 */
module coreMemory #(
    parameter int ADDR_BITS = 12
) (
    input  logic           CLOCK,
    input  pdp8Pkg::word_t i_addr,
    input  pdp8Pkg::word_t i_writeData,
    input  logic           i_write,
    output pdp8Pkg::word_t o_readData
);

    pdp8Pkg::word_t core [2**ADDR_BITS];   // should infer block RAM

    always_ff @(posedge CLOCK) begin
        if (i_write)
            core[i_addr[ADDR_BITS-1:0]] <= i_writeData;
        o_readData <= core[i_addr[ADDR_BITS-1:0]];  // upper bits alias when smaller
    end

endmodule

// File: logic/operateUnit.sv
/*
 * Combinational datapath for the operate groups and the TAD adder.
 * Works from MB as the instruction (or operand) and the current AC/LINK.
 */
module operateUnit (
    input  pdp8Pkg::word_t i_mb,
    input  pdp8Pkg::word_t i_ac,
    input  pdp8Pkg::word_t i_switches,
    input  logic           i_link,
    output pdp8Pkg::word_t o_group1Ac,
    output logic           o_group1Link,
    output logic           o_group2Skip,
    output pdp8Pkg::word_t o_group2Ac,
    output pdp8Pkg::word_t o_tadAc,
    output logic           o_tadLink
);

    pdp8Pkg::word_t rawAc;
    logic           rawLink;

    // TAD, carry out of AC complements LINK
    assign {o_tadLink, o_tadAc} = {i_link, i_ac} + {1'b0, i_mb};

    ////////////////////////////////////////
    // group 1
    ////////////////////////////////////////

    always_comb begin
        // CLA/CLL first, then CMA/CML, then IAC across LINK
        {rawLink, rawAc} = {(i_mb[6] ? 1'b0 : i_link) ^ i_mb[4],
                            (i_mb[7] ? 12'o0000 : i_ac) ^ (i_mb[5] ? 12'o7777 : 12'o0000)}
                           + {12'd0, i_mb[0]};
        case (i_mb[3:1])
            3'd1:    {o_group1Link, o_group1Ac} = {rawLink, rawAc[5:0], rawAc[11:6]};  // BSW
            3'd2:    {o_group1Link, o_group1Ac} = {rawAc, rawLink};                    // RAL
            3'd3:    {o_group1Link, o_group1Ac} = {rawAc[10:0], rawLink, rawAc[11]};   // RTL
            3'd4:    {o_group1Link, o_group1Ac} = {rawAc[0], rawLink, rawAc[11:1]};    // RAR
            3'd5:    {o_group1Link, o_group1Ac} = {rawAc[1:0], rawLink, rawAc[11:2]};  // RTR
            default: {o_group1Link, o_group1Ac} = {rawLink, rawAc};                    // no rotate
        endcase
    end

    ////////////////////////////////////////
    // group 2
    ////////////////////////////////////////

    assign o_group2Skip = ((i_mb[6] & i_ac[11])         // SMA
                         | (i_mb[5] & (i_ac == '0))     // SZA
                         | (i_mb[4] & i_link))          // SNL
                         ^ i_mb[3];                     // reverse sense

    // CLA then OSR
    assign o_group2Ac = (i_mb[7] ? 12'o0000 : i_ac) | (i_mb[2] ? i_switches : 12'o0000);

endmodule

// File: logic/majorStateCtl.sv
/*
 * Major-state control and the programmer-visible registers.
 * Handles panel keys while halted, then the read/modify/write/finish steps
 * of FETCH, DEFER and EXEC against the time states from memoryTiming.
 */
module majorStateCtl (
    input  logic                 CLOCK,
    input  logic                 RESET,
    consoleKeyIf.sink            keys,
    input  logic                 i_swStop,
    input  logic                 i_swStep,
    input  pdp8Pkg::word_t       i_switches,
    input  pdp8Pkg::timeState_t  i_timeState,
    input  logic                 i_phaseEnd,
    output logic                 o_cycleStart,
    output pdp8Pkg::word_t       o_memAddr,
    output pdp8Pkg::word_t       o_memWriteData,
    output logic                 o_memWrite,
    input  pdp8Pkg::word_t       i_memReadData,
    input  pdp8Pkg::word_t       i_group1Ac,
    input  logic                 i_group1Link,
    input  logic                 i_group2Skip,
    input  pdp8Pkg::word_t       i_group2Ac,
    input  pdp8Pkg::word_t       i_tadAc,
    input  logic                 i_tadLink,
    output pdp8Pkg::majorState_t o_majorState,
    output pdp8Pkg::word_t       o_ac,
    output logic                 o_link,
    output pdp8Pkg::word_t       o_pc,
    output pdp8Pkg::word_t       o_ma,
    output pdp8Pkg::word_t       o_mb,
    output pdp8Pkg::opcode_t     o_ir
);

    pdp8Pkg::majorState_t majorState, nextState, afterInstr;
    pdp8Pkg::word_t       ac, pc, ma, mb, effAddr;
    pdp8Pkg::word_t       finishAc, finishPc, finishMa;
    pdp8Pkg::opcode_t     ir;
    logic                 link, finishLink;
    logic                 ts1End, ts2End, ts3End, ts4End;
    logic                 idleHalt, keyCycle, haltReq;

    assign ts1End = i_phaseEnd && (i_timeState == pdp8Pkg::TS1);
    assign ts2End = i_phaseEnd && (i_timeState == pdp8Pkg::TS2);
    assign ts3End = i_phaseEnd && (i_timeState == pdp8Pkg::TS3);
    assign ts4End = i_phaseEnd && (i_timeState == pdp8Pkg::TS4);

    // console only listens when stopped and memory is quiet
    assign idleHalt = (majorState == pdp8Pkg::HALT) && (i_timeState == pdp8Pkg::IDLE);
    assign keyCycle = !keys.loadAddr && (keys.examine || keys.deposit || keys.cont || keys.start);

    // back to back cycles unless heading for HALT
    assign o_cycleStart = (idleHalt && keyCycle) || (ts4End && (nextState != pdp8Pkg::HALT));

    // current page or page zero
    assign effAddr = {mb[7] ? ma[11:7] : 5'd0, mb[6:0]};

    // STOP/STEP, or an HLT being fetched
    assign haltReq    = i_swStop || i_swStep ||
                        ((majorState == pdp8Pkg::FETCH) && ((mb & 12'o7403) == 12'o7402));
    assign afterInstr = haltReq ? pdp8Pkg::HALT : pdp8Pkg::FETCH;

    ////////////////////////////////////////
    // TS4 register updates
    ////////////////////////////////////////

    always_comb begin
        finishAc   = ac;
        finishLink = link;
        finishPc   = pc;
        finishMa   = ma;
        case (majorState)
            pdp8Pkg::FETCH: begin
                case (ir)
                    pdp8Pkg::OP_AND, pdp8Pkg::OP_TAD, pdp8Pkg::OP_ISZ,
                    pdp8Pkg::OP_DCA, pdp8Pkg::OP_JMS:
                        finishMa = effAddr;
                    pdp8Pkg::OP_JMP:
                        if (mb[8])
                            finishMa = effAddr;     // pointer fetch next
                        else
                            finishPc = effAddr;
                    pdp8Pkg::OP_OPR:
                        if (!mb[8]) begin
                            finishAc   = i_group1Ac;
                            finishLink = i_group1Link;
                        end else if (!mb[0]) begin
                            finishAc = i_group2Ac;
                            if (i_group2Skip)
                                finishPc = pc + 12'd1;
                        end
                    default: ;                      // IOT does nothing
                endcase
            end
            pdp8Pkg::DEFER: begin
                if (ir == pdp8Pkg::OP_JMP)
                    finishPc = mb;
                else
                    finishMa = mb;
            end
            pdp8Pkg::EXEC: begin
                case (ir)
                    pdp8Pkg::OP_AND: finishAc = ac & mb;
                    pdp8Pkg::OP_TAD: begin
                        finishAc   = i_tadAc;
                        finishLink = i_tadLink;
                    end
                    pdp8Pkg::OP_ISZ: if (mb == '0) finishPc = pc + 12'd1;  // skip on wrap
                    pdp8Pkg::OP_DCA: finishAc = '0;
                    pdp8Pkg::OP_JMS: finishPc = ma + 12'd1;
                    default: ;
                endcase
            end
            default: ;                              // EXAMINE/DEPOSIT leave registers alone
        endcase
    end

    ////////////////////////////////////////
    // state and register file
    ////////////////////////////////////////

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            majorState <= pdp8Pkg::HALT;
            nextState  <= pdp8Pkg::HALT;
            ac         <= '0;
            link       <= 1'b0;
            pc         <= '0;
            ma         <= '0;
            mb         <= '0;
            ir         <= '0;
        end else if (idleHalt) begin
            if (keys.loadAddr) begin
                pc <= i_switches;
                ma <= i_switches;
            end else if (keys.examine || keys.deposit) begin
                ma         <= pc;
                pc         <= pc + 12'd1;
                majorState <= keys.examine ? pdp8Pkg::EXAMINE : pdp8Pkg::DEPOSIT;
            end else if (keys.cont || keys.start) begin
                ma         <= pc;
                majorState <= pdp8Pkg::FETCH;
                if (keys.start) begin
                    ac   <= '0;
                    link <= 1'b0;
                end
            end
        end else begin
            if (ts1End)
                mb <= i_memReadData;                // core read lands in MB
            if (ts2End) begin
                case (majorState)
                    pdp8Pkg::FETCH: begin
                        ir <= mb[11:9];
                        pc <= pc + 12'd1;
                    end
                    pdp8Pkg::DEFER: if (ma[11:3] == 9'o001) mb <= mb + 12'd1;  // auto-index
                    pdp8Pkg::EXEC: begin
                        case (ir)
                            pdp8Pkg::OP_ISZ: mb <= mb + 12'd1;
                            pdp8Pkg::OP_DCA: mb <= ac;
                            pdp8Pkg::OP_JMS: mb <= pc;  // return address
                            default: ;
                        endcase
                    end
                    pdp8Pkg::DEPOSIT: mb <= i_switches;
                    default: ;
                endcase
            end
            if (ts3End) begin
                case (majorState)
                    pdp8Pkg::FETCH: begin
                        if (ir == pdp8Pkg::OP_IOT || ir == pdp8Pkg::OP_OPR)
                            nextState <= afterInstr;
                        else if (mb[8])
                            nextState <= pdp8Pkg::DEFER;
                        else
                            nextState <= (ir == pdp8Pkg::OP_JMP) ? afterInstr : pdp8Pkg::EXEC;
                    end
                    pdp8Pkg::DEFER:
                        nextState <= (ir == pdp8Pkg::OP_JMP) ? afterInstr : pdp8Pkg::EXEC;
                    pdp8Pkg::EXEC: nextState <= afterInstr;
                    default:       nextState <= pdp8Pkg::HALT;  // panel cycles stop
                endcase
            end
            if (ts4End) begin
                ac         <= finishAc;
                link       <= finishLink;
                pc         <= finishPc;
                ma         <= (nextState == pdp8Pkg::FETCH) ? finishPc : finishMa;
                majorState <= nextState;
            end
        end
    end

    assign o_memAddr      = ma;
    assign o_memWriteData = mb;
    assign o_memWrite     = ts3End;                 // write back at end of TS3

    assign o_majorState = majorState;
    assign o_ac         = ac;
    assign o_link       = link;
    assign o_pc         = pc;
    assign o_ma         = ma;
    assign o_mb         = mb;
    assign o_ir         = ir;

endmodule

// File: logic/pdp8Core.sv
/*
 * Top level of the PDP-8/L style processor.
 * Front-panel switches in, panel lights out; timing, debounce and the core
 * size are set by the parameters below.
 */
module pdp8Core #(
    parameter int PHASE_CYCLES    = 4,
    parameter int DEBOUNCE_CYCLES = 1000,
    parameter int ADDR_BITS       = 12
) (
    input  logic             CLOCK,
    input  logic             RESET,
    input  logic             i_swLoadAddr,
    input  logic             i_swDeposit,
    input  logic             i_swExamine,
    input  logic             i_swContinue,
    input  logic             i_swStart,
    input  logic             i_swStop,
    input  logic             i_swStep,
    input  pdp8Pkg::word_t   i_swSR,
    output pdp8Pkg::word_t   o_ac,
    output pdp8Pkg::word_t   o_ma,
    output pdp8Pkg::word_t   o_mb,
    output logic             o_link,
    output logic             o_run,
    output logic             o_fetch,
    output logic             o_defer,
    output logic             o_execute,
    output pdp8Pkg::opcode_t o_ir
);

    pdp8Pkg::timeState_t  timeState;
    pdp8Pkg::majorState_t majorState;
    pdp8Pkg::word_t       memReadData, memWriteData, memAddr;
    pdp8Pkg::word_t       group1Ac, group2Ac, tadAc;
    logic                 phaseEnd, cycleStart, memWrite;
    logic                 group1Link, group2Skip, tadLink;

    consoleKeyIf keyBus ();

    consoleKeys #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) keysInst (
        .CLOCK(CLOCK), .RESET(RESET),
        .i_swLoadAddr(i_swLoadAddr), .i_swDeposit(i_swDeposit),
        .i_swExamine(i_swExamine), .i_swContinue(i_swContinue),
        .i_swStart(i_swStart), .keys(keyBus.source)
    );

    memoryTiming #(.PHASE_CYCLES(PHASE_CYCLES)) timingInst (
        .CLOCK(CLOCK), .RESET(RESET), .i_cycleStart(cycleStart),
        .o_timeState(timeState), .o_phaseEnd(phaseEnd)
    );

    coreMemory #(.ADDR_BITS(ADDR_BITS)) memInst (
        .CLOCK(CLOCK), .i_addr(memAddr), .i_writeData(memWriteData),
        .i_write(memWrite), .o_readData(memReadData)
    );

    operateUnit operateInst (
        .i_mb(o_mb), .i_ac(o_ac), .i_switches(i_swSR), .i_link(o_link),
        .o_group1Ac(group1Ac), .o_group1Link(group1Link),
        .o_group2Skip(group2Skip), .o_group2Ac(group2Ac),
        .o_tadAc(tadAc), .o_tadLink(tadLink)
    );

    majorStateCtl ctlInst (
        .CLOCK(CLOCK), .RESET(RESET), .keys(keyBus.sink),
        .i_swStop(i_swStop), .i_swStep(i_swStep), .i_switches(i_swSR),
        .i_timeState(timeState), .i_phaseEnd(phaseEnd), .o_cycleStart(cycleStart),
        .o_memAddr(memAddr), .o_memWriteData(memWriteData), .o_memWrite(memWrite),
        .i_memReadData(memReadData),
        .i_group1Ac(group1Ac), .i_group1Link(group1Link), .i_group2Skip(group2Skip),
        .i_group2Ac(group2Ac), .i_tadAc(tadAc), .i_tadLink(tadLink),
        .o_majorState(majorState), .o_ac(o_ac), .o_link(o_link),
        .o_pc(),                                    // no PC lamp on this panel
        .o_ma(o_ma), .o_mb(o_mb), .o_ir(o_ir)
    );

    // panel lamps
    assign o_run     = (majorState != pdp8Pkg::HALT);
    assign o_fetch   = (majorState == pdp8Pkg::FETCH);
    assign o_defer   = (majorState == pdp8Pkg::DEFER);
    assign o_execute = (majorState == pdp8Pkg::EXEC);

endmodule

// File: verification/pdp8Core_assertions.sv
/*
 * Protocol checker bound into pdp8Core.
 * Watches the time-state sequence, the write strobe and the halted timing.
 */
module pdp8CoreAssertions (
    input logic                 CLOCK,
    input logic                 RESET,
    input pdp8Pkg::timeState_t  i_timeState,
    input pdp8Pkg::majorState_t i_majorState,
    input logic                 i_memWrite
);
    timeunit 1ns;
    timeprecision 100ps;

    // legal moves of the time-state register, holding counts as legal
    function automatic logic stepOk(pdp8Pkg::timeState_t prev, pdp8Pkg::timeState_t cur);
        case (prev)
            pdp8Pkg::IDLE: return (cur == pdp8Pkg::IDLE) || (cur == pdp8Pkg::TS1);
            pdp8Pkg::TS1:  return (cur == pdp8Pkg::TS1) || (cur == pdp8Pkg::TS2);
            pdp8Pkg::TS2:  return (cur == pdp8Pkg::TS2) || (cur == pdp8Pkg::TS3);
            pdp8Pkg::TS3:  return (cur == pdp8Pkg::TS3) || (cur == pdp8Pkg::TS4);
            pdp8Pkg::TS4:  return (cur == pdp8Pkg::TS4) || (cur == pdp8Pkg::TS1) ||
                                  (cur == pdp8Pkg::IDLE);  // chained or finished
            default:       return 1'b0;
        endcase
    endfunction

    timeOrder: assert property (@(posedge CLOCK) disable iff (RESET)
        stepOk($past(i_timeState), i_timeState))
        else $error("time state left its IDLE-TS1-TS2-TS3-TS4 order");

    // write-back lands on the last clock of TS3, right before TS4
    writeInTs3: assert property (@(posedge CLOCK) disable iff (RESET)
        i_memWrite |-> (i_timeState == pdp8Pkg::TS3) ##1 (i_timeState == pdp8Pkg::TS4))
        else $error("core write outside the end of TS3");

    haltIdle: assert property (@(posedge CLOCK) disable iff (RESET)
        (i_majorState == pdp8Pkg::HALT) |-> (i_timeState == pdp8Pkg::IDLE))
        else $error("memory cycle running while halted");

endmodule

bind pdp8Core pdp8CoreAssertions assertInst (
    .CLOCK(CLOCK), .RESET(RESET), .i_timeState(timeState),
    .i_majorState(majorState), .i_memWrite(memWrite)
);

// File: verification/pdp8CoreTb.sv
/*
 * Testbench for pdp8Core, driven only through the front panel.
 * Each table entry is deposited, read back, started and checked on halt;
 * a single-step run with STOP held closes the run.
 */
module pdp8CoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PHASE_CYCLES    = 4;
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int NUM_TESTS       = 10;
    localparam int MAX_WORDS       = 8;
    localparam int KEY_LOAD = 0, KEY_DEPOSIT = 1, KEY_EXAMINE = 2, KEY_START = 3;

    ////////////////////////////////////////
    // timeout budget
    ////////////////////////////////////////
    localparam int OP_CYCLES      = DEBOUNCE_CYCLES + 8 + 4 * PHASE_CYCLES;  // one panel op
    localparam int OPS_PER_TEST   = 2 * MAX_WORDS + 6;  // deposit, readback, start, result
    localparam int RUN_CYCLES     = 50 * 3 * 4 * PHASE_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * ((NUM_TESTS + 1) * OPS_PER_TEST * OP_CYCLES + RUN_CYCLES);

    logic             CLOCK, RESET;
    logic             i_swLoadAddr, i_swDeposit, i_swExamine, i_swContinue, i_swStart;
    logic             i_swStop, i_swStep;
    pdp8Pkg::word_t   i_swSR, o_ac, o_ma, o_mb;
    logic             o_link, o_run, o_fetch, o_defer, o_execute;
    pdp8Pkg::opcode_t o_ir;

    // program table
    string          testName   [NUM_TESTS];
    pdp8Pkg::word_t testStart  [NUM_TESTS];
    int             testLen    [NUM_TESTS];
    pdp8Pkg::word_t testWords  [NUM_TESTS * MAX_WORDS];
    pdp8Pkg::word_t expAc      [NUM_TESTS];
    logic           expLink    [NUM_TESTS];
    bit             hasResult  [NUM_TESTS];
    pdp8Pkg::word_t resAddr    [NUM_TESTS];
    pdp8Pkg::word_t resValue   [NUM_TESTS];
    bit             randomOps  [NUM_TESTS];   // words 5 and 6 replaced by random TAD operands

    pdp8Pkg::word_t block [MAX_WORDS];        // words of the program being loaded
    logic           sawFetch, sawDefer, sawExec;  // lamps lit during the last run
    int             numDefined = 0;
    int             errorCount = 0;
    int             cycleCount = 0;
    integer         seed       = 32'h756d4627;

    pdp8Core #(
        .PHASE_CYCLES(PHASE_CYCLES), .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES), .ADDR_BITS(12)
    ) dut (.*);

    always #4 CLOCK = ~CLOCK;

    always @(posedge CLOCK) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
            failRun("simulation timed out waiting for the DUT");
    end

    task automatic failRun(input string why);
        errorCount++;
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkWord(input string name, input string label,
                             input pdp8Pkg::word_t want, input pdp8Pkg::word_t got);
        if (got !== want)
            failRun($sformatf("[FAIL] %s %s expected %04o actual %04o", name, label, want, got));
    endtask

    task automatic checkBit(input string name, input string label, input logic want,
                            input logic got);
        if (got !== want)
            failRun($sformatf("[FAIL] %s %s expected %b actual %b", name, label, want, got));
    endtask

    task automatic checkOpcode(input string name, input pdp8Pkg::opcode_t want,
                               input pdp8Pkg::opcode_t got);
        if (got !== want)
            failRun($sformatf("[FAIL] %s IR expected %o actual %o", name, want, got));
    endtask

    // major-state lamps that lit up at some point of the last run
    task automatic checkLampsSeen(input string name, input logic wantFetch,
                                  input logic wantDefer, input logic wantExec);
        checkBit(name, "FETCH lamp", wantFetch, sawFetch);
        checkBit(name, "DEFER lamp", wantDefer, sawDefer);
        checkBit(name, "EXECUTE lamp", wantExec, sawExec);
    endtask

    // words packed first-to-last, eight always given
    task automatic addProgram(input string name, input pdp8Pkg::word_t start, input int len,
                              input logic [95:0] words, input pdp8Pkg::word_t ac,
                              input logic link, input bit withResult,
                              input pdp8Pkg::word_t rAddr, input pdp8Pkg::word_t rValue,
                              input bit rnd);
        testName[numDefined]  = name;
        testStart[numDefined] = start;
        testLen[numDefined]   = len;
        for (int k = 0; k < MAX_WORDS; k++)
            testWords[numDefined * MAX_WORDS + k] = words[95 - 12 * k -: 12];
        expAc[numDefined]     = ac;
        expLink[numDefined]   = link;
        hasResult[numDefined] = withResult;
        resAddr[numDefined]   = rAddr;
        resValue[numDefined]  = rValue;
        randomOps[numDefined] = rnd;
        numDefined++;
    endtask

    ////////////////////////////////////////
    // panel operations
    ////////////////////////////////////////

    task automatic holdSwitch(input int key);
        @(posedge CLOCK);
        #1;
        case (key)
            KEY_LOAD:    i_swLoadAddr = 1'b1;
            KEY_DEPOSIT: i_swDeposit  = 1'b1;
            KEY_EXAMINE: i_swExamine  = 1'b1;
            default:     i_swStart    = 1'b1;
        endcase
        repeat (DEBOUNCE_CYCLES + 4) @(posedge CLOCK);   // longer than the debounce
        #1;
        i_swLoadAddr = 1'b0;
        i_swDeposit  = 1'b0;
        i_swExamine  = 1'b0;
        i_swStart    = 1'b0;
    endtask

    task automatic loadAddress(input pdp8Pkg::word_t addr);
        @(posedge CLOCK);
        #1 i_swSR = addr;
        holdSwitch(KEY_LOAD);
        repeat (3) @(negedge CLOCK);        // release, pulse, register load
        while (o_ma !== addr)
            @(negedge CLOCK);
    endtask

    // key that starts memory cycles, done once RUN drops again
    task automatic runPanelCycle(input int key);
        holdSwitch(key);
        sawFetch = 1'b0;
        sawDefer = 1'b0;
        sawExec  = 1'b0;
        while (o_run !== 1'b1)
            @(negedge CLOCK);
        while (o_run !== 1'b0) begin
            sawFetch = sawFetch | o_fetch;
            sawDefer = sawDefer | o_defer;
            sawExec  = sawExec | o_execute;
            @(negedge CLOCK);
        end
    endtask

    task automatic depositBlock(input string name, input pdp8Pkg::word_t addr, input int n);
        loadAddress(addr);
        for (int k = 0; k < n; k++) begin
            @(posedge CLOCK);
            #1 i_swSR = block[k];
            runPanelCycle(KEY_DEPOSIT);
            checkWord(name, "deposit MA", addr + pdp8Pkg::word_t'(k), o_ma);
            checkWord(name, "deposit MB", block[k], o_mb);
        end
    endtask

    task automatic verifyBlock(input string name, input pdp8Pkg::word_t addr, input int n);
        loadAddress(addr);
        for (int k = 0; k < n; k++) begin
            runPanelCycle(KEY_EXAMINE);
            checkWord(name, "examine MA", addr + pdp8Pkg::word_t'(k), o_ma);
            checkWord(name, "examine MB", block[k], o_mb);
        end
    endtask

    task automatic runTest(input int t);
        logic [31:0]    rnd;
        pdp8Pkg::word_t wantAc;
        logic           wantLink;
        for (int k = 0; k < MAX_WORDS; k++)
            block[k] = testWords[t * MAX_WORDS + k];
        wantAc   = expAc[t];
        wantLink = expLink[t];
        if (randomOps[t]) begin
            rnd      = $random(seed);
            block[5] = rnd[11:0];
            rnd      = $random(seed);
            block[6] = rnd[11:0];
            {wantLink, wantAc} = {1'b0, block[5]} + {1'b0, block[6]};  // carry lands in LINK
        end
        depositBlock(testName[t], testStart[t], testLen[t]);
        verifyBlock(testName[t], testStart[t], testLen[t]);
        loadAddress(testStart[t]);          // SR keeps the start address for OSR
        runPanelCycle(KEY_START);
        checkWord(testName[t], "AC", wantAc, o_ac);
        checkBit(testName[t], "LINK", wantLink, o_link);
        checkOpcode(testName[t], pdp8Pkg::OP_OPR, o_ir);   // every program ends on HLT
        if (hasResult[t]) begin
            loadAddress(resAddr[t]);
            runPanelCycle(KEY_EXAMINE);
            checkWord(testName[t], "result word", resValue[t], o_mb);
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        CLOCK = 1'b0;
        RESET = 1'b1;
        {i_swLoadAddr, i_swDeposit, i_swExamine, i_swContinue, i_swStart} = '0;
        i_swStop = 1'b0;
        i_swStep = 1'b0;
        i_swSR   = '0;

        // name, start, words, AC, LINK, result?, result addr, result value, random
        addProgram("tadCarry", 12'o0200, 7, {12'o1205, 12'o1206, 12'o7402, 12'o0000,
            12'o0000, 12'o7777, 12'o0002, 12'o0000}, 12'o0001, 1'b1, 1'b0, 12'o0, 12'o0, 1'b0);
        addProgram("tadRandom", 12'o0200, 7, {12'o1205, 12'o1206, 12'o7402, 12'o0000,
            12'o0000, 12'o0000, 12'o0000, 12'o0000}, 12'o0, 1'b0, 1'b0, 12'o0, 12'o0, 1'b1);
        addProgram("andMask", 12'o0200, 7, {12'o1205, 12'o0206, 12'o7402, 12'o0000,
            12'o0000, 12'o5353, 12'o0707, 12'o0000}, 12'o0303, 1'b0, 1'b0, 12'o0, 12'o0, 1'b0);
        addProgram("dcaStore", 12'o0200, 6, {12'o1204, 12'o3205, 12'o7402, 12'o0000,
            12'o1234, 12'o0000, 12'o0000, 12'o0000}, 12'o0000, 1'b0,
            1'b1, 12'o0205, 12'o1234, 1'b0);
        addProgram("iszSkip", 12'o0200, 7, {12'o2205, 12'o7402, 12'o1206, 12'o7402,
            12'o0000, 12'o7777, 12'o0055, 12'o0000}, 12'o0055, 1'b0,
            1'b1, 12'o0205, 12'o0000, 1'b0);
        addProgram("jmsCall", 12'o0200, 8, {12'o4204, 12'o7402, 12'o0000, 12'o0000,
            12'o0000, 12'o1207, 12'o5604, 12'o0321}, 12'o0321, 1'b0,
            1'b1, 12'o0204, 12'o0201, 1'b0);
        addProgram("autoIndex", 12'o0010, 7, {12'o5013, 12'o0015, 12'o0000, 12'o1411,
            12'o7402, 12'o0000, 12'o2345, 12'o0000}, 12'o2345, 1'b0,
            1'b1, 12'o0011, 12'o0016, 1'b0);  // pointer at 0011 steps to 0016
        addProgram("group1Rotate", 12'o0200, 8, {12'o1207, 12'o7104, 12'o7012, 12'o7002,
            12'o7402, 12'o0000, 12'o0000, 12'o4321}, 12'o5021, 1'b1, 1'b0, 12'o0, 12'o0, 1'b0);
        addProgram("group1ClearInc", 12'o0200, 7, {12'o1206, 12'o7361, 12'o7120, 12'o7006,
            12'o7010, 12'o7402, 12'o0017, 12'o0000}, 12'o0001, 1'b0, 1'b0, 12'o0, 12'o0, 1'b0);
        addProgram("group2Skips", 12'o0200, 8, {12'o1207, 12'o7500, 12'o7200, 12'o7430,
            12'o7200, 12'o7640, 12'o7406, 12'o4000}, 12'o0200, 1'b0, 1'b0, 12'o0, 12'o0, 1'b0);

        repeat (16) @(posedge CLOCK);
        #1 RESET = 1'b0;
        @(negedge CLOCK);
        checkBit("reset", "RUN", 1'b0, o_run);
        checkWord("reset", "AC", 12'o0, o_ac);
        checkWord("reset", "MA", 12'o0, o_ma);
        checkWord("reset", "MB", 12'o0, o_mb);
        checkBit("reset", "LINK", 1'b0, o_link);

        for (int t = 0; t < NUM_TESTS; t++)
            runTest(t);

        // STOP held, START runs one indirect TAD and halts with PC on the next word
        block[0] = 12'o1702;                // TAD I 0302
        block[1] = 12'o7402;
        block[2] = 12'o0303;                // pointer
        block[3] = 12'o0123;
        depositBlock("singleStep", 12'o0300, 4);
        @(posedge CLOCK);
        #1 i_swStop = 1'b1;
        loadAddress(12'o0300);
        runPanelCycle(KEY_START);
        checkWord("singleStep", "AC", 12'o0123, o_ac);
        checkOpcode("singleStep", pdp8Pkg::OP_TAD, o_ir);
        checkLampsSeen("singleStep", 1'b1, 1'b1, 1'b1);
        runPanelCycle(KEY_EXAMINE);
        checkLampsSeen("singleStep examine", 1'b0, 1'b0, 1'b0);
        checkWord("singleStep", "PC in MA", 12'o0301, o_ma);
        checkWord("singleStep", "next word", 12'o7402, o_mb);
        @(posedge CLOCK);
        #1 i_swStop = 1'b0;

        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: pdp8Core.f
logic/pdp8Pkg.sv
logic/consoleKeyIf.sv
logic/consoleKeys.sv
logic/memoryTiming.sv
logic/coreMemory.sv
logic/operateUnit.sv
logic/majorStateCtl.sv
logic/pdp8Core.sv
verification/pdp8Core_assertions.sv
verification/pdp8CoreTb.sv
